// ==== irq_stimulus.txt ====
# Columns: command, then up to three hex values
# T test | W addr data resp | R addr data resp | I irq_i | P idle | F idle | N cycles
# register access, masks and SLVERR
T 1
R 0 00000000 0
W 4 ffffffff 0
R 4 ffff0888 0
I 0001ffff
N 2
R 8 00010888 0
W 8 12345678 2
R 8 00010888 0
I 00000000
N 2
R 8 00000000 0
R 6 00000000 2
W 2 00000001 2
R c 00000000 0
# priority order 11, 3, 7, then 31 two cycles after irq_i
T 2
I 00000888
W 0 00000008 0
N 4
R c 8000000b 0
I 00000088
W 0 00000008 0
N 4
R c 80000003 0
I 00000080
W 0 00000008 0
N 4
R c 80000007 0
I 00000000
N 2
W 0 00000008 0
I 80010800
N 4
R c 8000001f 0
# trap bookkeeping, no second ack until mstatus.mie is set again
T 3
R 0 00000000 0
N 6
R c 8000001f 0
I 00010000
W 0 00000008 0
N 4
R 0 00000000 0
R c 80000010 0
# disabled and reserved lines, then global enable clear
T 4
W 4 00010000 0
I 7ffe0777
W 0 00000008 0
N 6
R 0 00000008 0
R 8 7ffe0000 0
W 0 00000000 0
I 00010000
N 6
R c 80000010 0
I 00000000
W 4 00000000 0
# WFI sleep with idle and busy pipeline, wake with mstatus.mie clear
T 5
W 4 00100000 0
P 1
F 1
N 4
I 00100000
N 3
I 00000000
P 0
F 0
N 5
P 1
N 3
I 00100000
N 3
I 00000000
R 0 00000000 0
R c 80000010 0

// ==== list.f ====
irq_pkg.sv
irq_csr_axil.sv
irq_arbiter.sv
irq_wfi_sleep.sv
irq_unit_top.sv
tb_irq_checker.sv
tb_irq_unit.sv

// ==== Makefile ====
# Verilator build and run of the interrupt unit testbench
SRCS := $(shell cat list.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_irq_unit: list.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_irq_unit -f list.f

run: obj_dir/Vtb_irq_unit irq_stimulus.txt
	./obj_dir/Vtb_irq_unit | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_irq_unit.sv ====
// ------------------------------
// Testbench for the interrupt unit, run from the project root
// Commands come from irq_stimulus.txt, inputs change on the falling edge
// Cycle by cycle checks live in tb_irq_checker
// ------------------------------
`timescale 1ns/1ns

module tb_irq_unit;
  import irq_pkg::*;

  logic                clk;
  logic                rst_n;
  logic [NUM_IRQ-1:0]  irq;
  axil_req_t           req;
  axil_rsp_t           rsp;
  logic                irq_ack;
  logic [IRQ_ID_W-1:0] irq_id;
  logic                wfi;
  logic                pipe_idle;
  logic                core_sleep;

  // Parsed command stream
  byte         cmd_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  logic [31:0] arg_c_q[$];

  int cycles = 0;
  int cycle_limit = 0;
  int checks = 0;
  int errors = 0;
  int chk_errors;
  int chk_checks;
  int tests = 0;
  int test_id = -1;
  int test_base = 0;
  int total;

  irq_unit_top uut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .irq_i        (irq),
    .axil_req_i   (req),
    .axil_rsp_o   (rsp),
    .irq_ack_o    (irq_ack),
    .irq_id_o     (irq_id),
    .wfi_i        (wfi),
    .pipe_idle_i  (pipe_idle),
    .core_sleep_o (core_sleep)
  );

  tb_irq_checker u_chk (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .irq_i        (irq),
    .axil_req_i   (req),
    .axil_rsp_i   (rsp),
    .irq_ack_i    (irq_ack),
    .irq_id_i     (irq_id),
    .wfi_i        (wfi),
    .pipe_idle_i  (pipe_idle),
    .core_sleep_i (core_sleep),
    .err_cnt_o    (chk_errors),
    .chk_cnt_o    (chk_checks)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Limit is set once the stimulus is loaded
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic load_stimulus();
    int          fd;
    string       line;
    byte         c;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    fd = $fopen("irq_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open irq_stimulus.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        // Skip comments and blank lines
        if (line.len() > 1 && line[0] != "#") begin
          a = '0;
          b = '0;
          d = '0;
          void'($sscanf(line, "%c %h %h %h", c, a, b, d));
          cmd_q.push_back(c);
          arg_a_q.push_back(a);
          arg_b_q.push_back(b);
          arg_c_q.push_back(d);
          cycle_limit += (c == "N") ? 64 + int'(a) : 64;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Address and data together, response taken on the following edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp_resp);
    req.aw_addr  = addr[ADDR_W-1:0];
    req.w_data   = data;
    req.aw_valid = 1'b1;
    req.w_valid  = 1'b1;
    req.b_ready  = 1'b1;
    do begin
      @(posedge clk);
    end while (!rsp.aw_ready);
    // Data channel is taken in the same cycle as the address
    check_value("w_ready", 32'(rsp.w_ready), 32'd1);
    @(negedge clk);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    do begin
      @(posedge clk);
    end while (!rsp.b_valid);
    check_value($sformatf("b_resp @%0h", addr), 32'(rsp.b_resp), exp_resp);
    @(negedge clk);
    req.b_ready = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic [31:0] exp_resp);
    req.ar_addr  = addr[ADDR_W-1:0];
    req.ar_valid = 1'b1;
    req.r_ready  = 1'b1;
    do begin
      @(posedge clk);
    end while (!rsp.ar_ready);
    @(negedge clk);
    req.ar_valid = 1'b0;
    do begin
      @(posedge clk);
    end while (!rsp.r_valid);
    check_value($sformatf("r_data @%0h", addr), rsp.r_data, exp_data);
    check_value($sformatf("r_resp @%0h", addr), 32'(rsp.r_resp), exp_resp);
    @(negedge clk);
    req.r_ready = 1'b0;
  endtask

  // Random pause between bus commands
  task automatic idle_gap();
    repeat ($urandom % 3) @(negedge clk);
  endtask

  task automatic end_test();
    int n;
    n = errors + chk_errors - test_base;
    tests++;
    if (n == 0) begin
      $display("test %0d: ok", test_id);
    end else begin
      $display("test %0d: %0d errors", test_id, n);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    rst_n     = 1'b0;
    irq       = '0;
    req       = '0;
    wfi       = 1'b0;
    pipe_idle = 1'b0;
    void'($urandom(32'hfc3e));
    load_stimulus();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    foreach (cmd_q[k]) begin
      case (cmd_q[k])
        "T": begin
          if (test_id >= 0) begin
            end_test();
          end
          test_id   = int'(arg_a_q[k]);
          test_base = errors + chk_errors;
        end
        "W": begin
          bus_write(arg_a_q[k], arg_b_q[k], arg_c_q[k]);
          idle_gap();
        end
        "R": begin
          bus_read(arg_a_q[k], arg_b_q[k], arg_c_q[k]);
          idle_gap();
        end
        "I": irq = arg_a_q[k];
        "P": pipe_idle = arg_a_q[k][0];
        "F": begin
          wfi       = 1'b1;
          pipe_idle = arg_a_q[k][0];
          @(negedge clk);
          wfi = 1'b0;
        end
        "N": repeat (arg_a_q[k]) @(negedge clk);
        default: begin
          errors++;
          $display("unknown stimulus command '%c' at entry %0d", cmd_q[k], k);
        end
      endcase
    end
    if (test_id >= 0) begin
      end_test();
    end
    total = errors + chk_errors;
    $display("tests %0d, checks %0d, errors %0d", tests, checks + chk_checks, total);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb_irq_checker.sv ====
// ------------------------------
// Reference model of the interrupt unit, compared on every rising edge
// Model state follows the bus writes and irq_i seen at the DUT pins
// Only mcause reads are checked here, other reads are checked by the driver
// ------------------------------
`timescale 1ns/1ns

module tb_irq_checker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [irq_pkg::NUM_IRQ-1:0]  irq_i,
  input  irq_pkg::axil_req_t           axil_req_i,
  input  irq_pkg::axil_rsp_t           axil_rsp_i,
  input  logic                         irq_ack_i,
  input  logic [irq_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                         wfi_i,
  input  logic                         pipe_idle_i,
  input  logic                         core_sleep_i,
  output int                           err_cnt_o,
  output int                           chk_cnt_o
);
  import irq_pkg::*;

  // Model copies of the architectural state
  logic [31:0] mip_m;
  logic [31:0] mie_m;
  logic [31:0] mcause_m;
  logic        mst_m;
  logic        ack_m;
  logic [4:0]  id_m;
  wfi_state_e  st_m;
  logic [31:0] pend;
  // mcause read in flight
  logic        rd_pend;
  logic [31:0] rd_exp;
  int          err_cnt = 0;
  int          chk_cnt = 0;

  // Strongest line first, 31 down to 16, then 11, 3, 7
  function automatic logic [4:0] first_pending(input logic [31:0] p);
    for (int i = 31; i >= 16; i--) begin
      if (p[i]) begin
        return 5'(i);
      end
    end
    return p[11] ? 5'd11 : (p[3] ? 5'd3 : 5'd7);
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  assign pend      = mip_m & mie_m;
  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_m    <= '0;
      mie_m    <= '0;
      mcause_m <= '0;
      mst_m    <= 1'b0;
      ack_m    <= 1'b0;
      id_m     <= '0;
      st_m     <= WFI_RUN;
      rd_pend  <= 1'b0;
      rd_exp   <= '0;
    end else begin
      // ------------------------------
      // Compare against the model state before this edge
      // ------------------------------
      check_equal("irq_ack_o", 32'(irq_ack_i), 32'(ack_m));
      if (ack_m) begin
        check_equal("irq_id_o", 32'(irq_id_i), 32'(id_m));
      end
      check_equal("core_sleep_o", 32'(core_sleep_i), 32'(st_m == WFI_SLEEP));
      if (rd_pend && axil_rsp_i.r_valid && axil_req_i.r_ready) begin
        check_equal("mcause", axil_rsp_i.r_data, rd_exp);
        rd_pend <= 1'b0;
      end
      // Read data is taken when the address is accepted
      if (axil_req_i.ar_valid && axil_rsp_i.ar_ready && axil_req_i.ar_addr == ADDR_MCAUSE) begin
        rd_pend <= 1'b1;
        rd_exp  <= mcause_m;
      end

      // ------------------------------
      // Model update
      // ------------------------------
      if (axil_req_i.aw_valid && axil_req_i.w_valid && axil_rsp_i.aw_ready) begin
        if (axil_req_i.aw_addr == ADDR_MIE) begin
          mie_m <= axil_req_i.w_data & VALID_IRQ_MASK;
        end
        if (axil_req_i.aw_addr == ADDR_MSTATUS) begin
          mst_m <= axil_req_i.w_data[MSTATUS_MIE_BIT];
        end
        if (axil_req_i.aw_addr == ADDR_MCAUSE) begin
          mcause_m <= axil_req_i.w_data;
        end
      end
      // Trap entry comes last so it beats a bus write
      if (ack_m) begin
        mst_m    <= 1'b0;
        mcause_m <= 32'h8000_0000 | 32'(id_m);
      end
      ack_m <= (pend != '0) && mst_m && !ack_m;
      id_m  <= first_pending(pend);
      mip_m <= irq_i & VALID_IRQ_MASK;
      // Sleep wakes on any pending enabled line, mstatus.mie ignored
      case (st_m)
        WFI_RUN: st_m <= wfi_i ? WFI_SETTLE : WFI_RUN;
        WFI_SLEEP: st_m <= (pend != '0) ? WFI_RUN : WFI_SLEEP;
        default: st_m <= (pend != '0) ? WFI_RUN : (pipe_idle_i ? WFI_SLEEP : WFI_WAIT_IDLE);
      endcase
    end
  end

endmodule

// ==== irq_unit_top.sv ====
// ------------------------------
// Machine-mode interrupt unit top level
// Bus access through AXI4-Lite, registers at byte addresses 0..12
// irq_id_o only valid while irq_ack_o is high
// ------------------------------
`timescale 1ns/1ns

module irq_unit_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [irq_pkg::NUM_IRQ-1:0]  irq_i,
  input  irq_pkg::axil_req_t           axil_req_i,
  output irq_pkg::axil_rsp_t           axil_rsp_o,
  output logic                         irq_ack_o,
  output logic [irq_pkg::IRQ_ID_W-1:0] irq_id_o,
  input  logic                         wfi_i,
  input  logic                         pipe_idle_i,
  output logic                         core_sleep_o
);
  import irq_pkg::*;

  // ------------------------------
  // Internal wiring
  // ------------------------------
  logic [NUM_IRQ-1:0] mie;
  logic               mstatus_mie;
  logic [NUM_IRQ-1:0] mip;
  irq_ack_t           ack;
  logic               wake;

  // Registers and bus slave
  irq_csr_axil u_csr (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .axil_req_i    (axil_req_i),
    .axil_rsp_o    (axil_rsp_o),
    .mip_i         (mip),
    .ack_i         (ack),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie)
  );

  // Pending register and priority pick
  irq_arbiter u_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .mip_o         (mip),
    .ack_o         (ack),
    .wake_o        (wake)
  );

  // WFI sleep
  irq_wfi_sleep u_wfi (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wfi_i        (wfi_i),
    .pipe_idle_i  (pipe_idle_i),
    .wake_i       (wake),
    .core_sleep_o (core_sleep_o)
  );

  assign irq_ack_o = ack.valid;
  assign irq_id_o  = ack.id;

endmodule

// ==== irq_wfi_sleep.sv ====
// ------------------------------
// WFI sleep controller driving core_sleep_o
// wfi_i is a one-cycle pulse when a WFI retires
// Any pending enabled line wakes the core, whatever mstatus.mie is
// ------------------------------
`timescale 1ns/1ns

module irq_wfi_sleep (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wfi_i,
  input  logic pipe_idle_i,
  input  logic wake_i,
  output logic core_sleep_o
);
  import irq_pkg::*;

  wfi_state_e state_q;
  wfi_state_e state_d;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      WFI_RUN: begin
        if (wfi_i) begin
          state_d = WFI_SETTLE;
        end
      end
      // First cycle after retire, sleep at once if the pipe is quiet
      WFI_SETTLE, WFI_WAIT_IDLE: begin
        if (wake_i) begin
          state_d = WFI_RUN;
        end else if (pipe_idle_i) begin
          state_d = WFI_SLEEP;
        end else begin
          state_d = WFI_WAIT_IDLE;
        end
      end
      WFI_SLEEP: begin
        if (wake_i) begin
          state_d = WFI_RUN;
        end
      end
      default: state_d = WFI_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WFI_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign core_sleep_o = (state_q == WFI_SLEEP);

  // ------------------------------
  // Assertions
  // ------------------------------
  // No sleep outside a WFI, and never sooner than the latency after one
  a_no_early_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == WFI_RUN |-> !core_sleep_o [*WFI_TO_SLEEP_LATENCY])
    else $error("core_sleep_o high outside a WFI");

  // Pending enabled interrupt drops sleep on the next cycle
  a_wake_drops_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o && wake_i |=> !core_sleep_o)
    else $error("core_sleep_o still high after wake");

endmodule

// ==== irq_arbiter.sv ====
// ------------------------------
// Samples irq_i into mip and picks one interrupt by fixed priority
// Order is 31 down to 16, then 11, 3, 7
// Acknowledge is registered, two clocks after irq_i is sampled
// ------------------------------
`timescale 1ns/1ns

module irq_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [irq_pkg::NUM_IRQ-1:0] irq_i,
  input  logic [irq_pkg::NUM_IRQ-1:0] mie_i,
  input  logic                        mstatus_mie_i,
  output logic [irq_pkg::NUM_IRQ-1:0] mip_o,
  output irq_pkg::irq_ack_t           ack_o,
  output logic                        wake_o
);
  import irq_pkg::*;

  // ------------------------------
  // Declarations
  // ------------------------------
  logic [NUM_IRQ-1:0]  mip_q;
  logic [NUM_IRQ-1:0]  pend_en;
  logic [IRQ_ID_W-1:0] winner;
  logic                ack_valid_q;
  logic [IRQ_ID_W-1:0] ack_id_q;

  // Highest-priority pending line
  // Lower priorities go first so the later checks overwrite them
  function automatic logic [IRQ_ID_W-1:0] pick_winner(input logic [NUM_IRQ-1:0] pend);
    logic [IRQ_ID_W-1:0] id;
    id = '0;
    if (pend[7]) begin
      id = 5'd7;
    end
    if (pend[3]) begin
      id = 5'd3;
    end
    if (pend[11]) begin
      id = 5'd11;
    end
    // Upper lines, 31 ends up strongest
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend[i]) begin
        id = i[IRQ_ID_W-1:0];
      end
    end
    return id;
  endfunction

  // ------------------------------
  // Pending register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign pend_en = mip_q & mie_i;
  assign winner  = pick_winner(pend_en);

  // Wake ignores the global enable
  assign wake_o = |pend_en;

  // ------------------------------
  // Acknowledge
  // ------------------------------
  // Blocked for one cycle after each ack so it stays a pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_valid_q <= 1'b0;
    end else begin
      ack_valid_q <= (|pend_en) && mstatus_mie_i && !ack_valid_q;
    end
  end

  // Id only meaningful while ack is high
  always_ff @(posedge clk_i) begin
    if (|pend_en) begin
      ack_id_q <= winner;
    end
  end

  assign mip_o       = mip_q;
  assign ack_o.valid = ack_valid_q;
  assign ack_o.id    = ack_id_q;

  // ------------------------------
  // Assertions
  // ------------------------------
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o.valid |=> !ack_o.valid)
    else $error("irq ack high for more than one cycle");

  // Winner must be implemented and was enabled when it was chosen
  a_id_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o.valid |-> VALID_IRQ_MASK[ack_o.id] &&
                    (($past(mie_i) & (32'd1 << ack_o.id)) != '0))
    else $error("irq id %0d is reserved or disabled", ack_o.id);

  // Global enable was set in the cycle that produced the ack
  a_ack_needs_mie: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o.valid |-> $past(mstatus_mie_i))
    else $error("irq ack %0d with mstatus.mie clear", ack_o.id);

endmodule

// ==== irq_csr_axil.sv ====
// ------------------------------
// AXI4-Lite slave for mstatus.mie, mie, mip and mcause
// One write and one read outstanding at a time
// Writes to mip and unknown addresses give SLVERR and change nothing
// No MPIE or mret, software sets mstatus.mie again itself
// ------------------------------
`timescale 1ns/1ns

module irq_csr_axil (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  irq_pkg::axil_req_t         axil_req_i,
  output irq_pkg::axil_rsp_t         axil_rsp_o,
  input  logic [irq_pkg::NUM_IRQ-1:0] mip_i,
  input  irq_pkg::irq_ack_t          ack_i,
  output logic [irq_pkg::NUM_IRQ-1:0] mie_o,
  output logic                       mstatus_mie_o
);
  import irq_pkg::*;

  // ------------------------------
  // Declarations
  // ------------------------------
  // Handshake strobes
  logic wr_go;
  logic rd_go;
  logic wr_ok;
  logic rd_ok;

  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] ack_cause;

  // Response channel state
  logic              b_valid_q;
  axil_resp_e        b_resp_q;
  logic              r_valid_q;
  axil_resp_e        r_resp_q;
  logic [DATA_W-1:0] r_data_q;

  // Architectural state
  logic [NUM_IRQ-1:0] mie_q;
  logic               mstatus_mie_q;
  logic [DATA_W-1:0]  mcause_q;

  // ------------------------------
  // Handshakes
  // ------------------------------
  // Write needs address and data together and a free response slot
  assign wr_go = axil_req_i.aw_valid && axil_req_i.w_valid && !b_valid_q;
  // Read needs a free read data slot
  assign rd_go = axil_req_i.ar_valid && !r_valid_q;

  // mip is read-only, so it is not a legal write target
  assign wr_ok = (axil_req_i.aw_addr == ADDR_MSTATUS) ||
                 (axil_req_i.aw_addr == ADDR_MIE)     ||
                 (axil_req_i.aw_addr == ADDR_MCAUSE);

  // Read decode, unknown addresses return zero
  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    case (axil_req_i.ar_addr)
      ADDR_MSTATUS: rd_data[MSTATUS_MIE_BIT] = mstatus_mie_q;
      ADDR_MIE:     rd_data = mie_q;
      ADDR_MIP:     rd_data = mip_i;
      ADDR_MCAUSE:  rd_data = mcause_q;
      default:      rd_ok = 1'b0;
    endcase
  end

  // Cause word recorded on acknowledge
  always_comb begin
    ack_cause                 = '0;
    ack_cause[MCAUSE_IRQ_BIT] = 1'b1;
    ack_cause[IRQ_ID_W-1:0]   = ack_i.id;
  end

  // ------------------------------
  // Response channels
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      // b valid holds until the manager takes it
      if (wr_go) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_go) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payload, only loaded on acceptance
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_go) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q         <= '0;
      mstatus_mie_q <= 1'b0;
      mcause_q      <= '0;
    end else begin
      if (wr_go && wr_ok) begin
        case (axil_req_i.aw_addr)
          ADDR_MSTATUS: mstatus_mie_q <= axil_req_i.w_data[MSTATUS_MIE_BIT];
          ADDR_MIE:     mie_q <= axil_req_i.w_data & VALID_IRQ_MASK;
          ADDR_MCAUSE:  mcause_q <= axil_req_i.w_data;
          default:      mcause_q <= mcause_q;
        endcase
      end
      // Trap entry overrides a bus write in the same cycle
      if (ack_i.valid) begin
        mstatus_mie_q <= 1'b0;
        mcause_q      <= ack_cause;
      end
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign axil_rsp_o.aw_ready = wr_go;
  assign axil_rsp_o.w_ready  = wr_go;
  assign axil_rsp_o.b_resp   = b_resp_q;
  assign axil_rsp_o.b_valid  = b_valid_q;
  assign axil_rsp_o.ar_ready = rd_go;
  assign axil_rsp_o.r_data   = r_data_q;
  assign axil_rsp_o.r_resp   = r_resp_q;
  assign axil_rsp_o.r_valid  = r_valid_q;

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;

  // ------------------------------
  // Assertions
  // ------------------------------
  // Write response is stable until the manager accepts it
  a_b_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_o.b_valid && !axil_req_i.b_ready |=>
      axil_rsp_o.b_valid && $stable(axil_rsp_o.b_resp))
    else $error("b_valid dropped or changed before b_ready");

  // Reserved lines can never be enabled
  a_mie_clean: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mie_o & ~VALID_IRQ_MASK) == '0)
    else $error("mie holds reserved bits: 0x%08x", mie_o);

endmodule

// ==== irq_pkg.sv ====
// ------------------------------
// Shared constants, bus structs and state encodings for the interrupt unit
// Bus is AXI4-Lite with whole-word writes only, no write strobes
// Only lines 31..16, 11, 7 and 3 are implemented
// ------------------------------
package irq_pkg;

  // ------------------------------
  // Interrupt lines
  // ------------------------------
  localparam int NUM_IRQ  = 32;
  localparam int IRQ_ID_W = 5;

  // Implemented lines, everything else reads as zero
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  localparam logic [ADDR_W-1:0] ADDR_MSTATUS = 4'h0;
  localparam logic [ADDR_W-1:0] ADDR_MIE     = 4'h4;
  localparam logic [ADDR_W-1:0] ADDR_MIP     = 4'h8;
  localparam logic [ADDR_W-1:0] ADDR_MCAUSE  = 4'hc;

  // Global enable inside mstatus
  localparam int MSTATUS_MIE_BIT = 3;
  // Interrupt flag inside mcause
  localparam int MCAUSE_IRQ_BIT  = 31;

  // Cycles from a retired WFI to core sleep, pipeline idle
  localparam int WFI_TO_SLEEP_LATENCY = 2;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  typedef enum logic [1:0] {
    WFI_RUN,
    WFI_SETTLE,
    WFI_WAIT_IDLE,
    WFI_SLEEP
  } wfi_state_e;

  // ------------------------------
  // Bus and acknowledge structs
  // ------------------------------
  // Manager to slave
  typedef struct packed {
    logic [ADDR_W-1:0] aw_addr;
    logic              aw_valid;
    logic [DATA_W-1:0] w_data;
    logic              w_valid;
    logic              b_ready;
    logic [ADDR_W-1:0] ar_addr;
    logic              ar_valid;
    logic              r_ready;
  } axil_req_t;

  // Slave to manager
  typedef struct packed {
    logic              aw_ready;
    logic              w_ready;
    axil_resp_e        b_resp;
    logic              b_valid;
    logic              ar_ready;
    logic [DATA_W-1:0] r_data;
    axil_resp_e        r_resp;
    logic              r_valid;
  } axil_rsp_t;

  // Arbiter winner, valid for one cycle
  typedef struct packed {
    logic                valid;
    logic [IRQ_ID_W-1:0] id;
  } irq_ack_t;

endpackage
